// File: hw/lcd_pkg.sv
// fixed 128x64 panel geometry and short simulation wait counts, so a real board must raise the waits
package lcd_pkg;

	// --------------------------------------------------
	// geometry
	localparam int SCREEN_WIDTH  = 128;  // pixels per row
	localparam int SCREEN_HEIGHT = 64;   // rows
	localparam int SCREEN_HOFFS  = 0;    // first column in controller ram
	localparam int SCREEN_VOFFS  = 0;    // first row in controller ram
	localparam int HCTR_BITS     = $clog2(SCREEN_WIDTH);
	localparam int VCTR_BITS     = $clog2(SCREEN_HEIGHT);
	localparam int PIXEL_BITS    = 16;   // rgb565

	// window corners as sent with caset / raset
	localparam logic [15:0] X_START = 16'(SCREEN_HOFFS);
	localparam logic [15:0] X_END   = 16'(SCREEN_HOFFS + SCREEN_WIDTH - 1);
	localparam logic [15:0] Y_START = 16'(SCREEN_VOFFS);
	localparam logic [15:0] Y_END   = 16'(SCREEN_VOFFS + SCREEN_HEIGHT - 1);

	// memory access control flags
	localparam logic MADCTL_HINV   = 1'b1;  // mirror columns
	localparam logic MADCTL_VINV   = 1'b0;  // mirror rows
	localparam logic MADCTL_HVINV  = 1'b1;  // swap rows and columns
	localparam logic MADCTL_RGBINV = 1'b0;  // bgr order when set
	localparam logic [7:0] MADCTL_BITS =
		{MADCTL_HINV, MADCTL_VINV, MADCTL_HVINV, 1'b0, MADCTL_RGBINV, 3'b000};
	localparam logic [7:0] COLMOD_16BIT = 8'h55;  // 16 bit per pixel on both interfaces

	// --------------------------------------------------
	// wait times in system cycles
	localparam int WAIT_RESET       = 4;   // panel reset pulse
	localparam int WAIT_AFTER_SLEEP = 8;   // after reset release and after sleep out
	localparam int WAIT_UPDATE      = 16;  // min gap between frames
	// the sum bounds every single wait
	localparam int WAIT_BITS = $clog2(WAIT_RESET + WAIT_AFTER_SLEEP + WAIT_UPDATE + 1);

	// controller commands in use
	typedef enum logic [7:0] {
		SLPOUT = 8'h11,
		INVON  = 8'h21,
		DISPON = 8'h29,
		CASET  = 8'h2a,
		RASET  = 8'h2b,
		RAMWR  = 8'h2c,
		MADCTL = 8'h36,
		COLMOD = 8'h3a
	} lcd_opcode_e;

	localparam int INIT_BYTES = 17;  // commands plus their arguments

endpackage

// File: hw/serial_pkg.sv
// serial link types and sizes, FIFO_DEPTH must be a power of two and CLK_DIV at least one
package serial_pkg;

	// --------------------------------------------------
	// one byte on the wire with its dc level
	typedef struct packed {
		logic       dc;       // 1 data, 0 command
		logic [7:0] payload;  // msb goes out first
	} lcd_byte_t;

	// serial clock
	localparam int CLK_DIV  = 2;  // system cycles per sclk half period
	localparam int DIV_BITS = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	// --------------------------------------------------
	// byte buffer between sequencer and shifter
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // pointers wrap on their own

endpackage

// File: hw/color_bars.sv
// eight rgb565 colour bars picked by the top three column bits and identical on every row
module color_bars
	import lcd_pkg::*;
(
	input  logic [HCTR_BITS-1:0]  hpix,
	input  logic [VCTR_BITS-1:0]  vpix,     // not used by the bar rule
	output logic [PIXEL_BITS-1:0] pattern
);

	logic [2:0] bar;  // SCREEN_WIDTH/8 columns each

	assign bar = hpix[HCTR_BITS-1 -: 3];

	// each bar bit switches one colour field fully on
	always_comb begin
		pattern = {
			{5{bar[2]}},  // red
			{6{bar[1]}},  // green
			{5{bar[0]}}   // blue
		};
	end

endmodule

// File: hw/frame_sequencer.sv
// producer for the byte FIFO, external pixel must be valid two edges after hpix/vpix change
module frame_sequencer
	import lcd_pkg::*;
	import serial_pkg::*;
(
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  update,       // start a frame once armed
	input  logic                  testpattern,  // 1 takes the colour bars
	input  logic [PIXEL_BITS-1:0] pixel,
	input  logic [PIXEL_BITS-1:0] pattern,
	input  logic                  full,
	output logic [HCTR_BITS-1:0]  hpix,
	output logic [VCTR_BITS-1:0]  vpix,
	output logic                  push,
	output lcd_byte_t             push_byte,
	output logic                  lcd_rst
);

	typedef enum logic [3:0] {
		ST_RESET,        // panel reset pulse
		ST_AFTER_RESET,
		ST_INIT,         // one init byte per free slot
		ST_SLEEP_WAIT,   // after slpout
		ST_UPDATE_WAIT,  // frame gap
		ST_UPDATE_ARM,   // waits for update
		ST_START_WRITE,  // ramwr
		ST_FETCH,        // lets the pixel source settle
		ST_HIGH_BYTE,
		ST_LOW_BYTE
	} state_e;

	state_e                        state;
	logic [WAIT_BITS-1:0]          wait_ctr;
	logic [WAIT_BITS-1:0]          wait_limit;
	logic                          timed;      // state runs the wait counter
	logic                          wait_done;
	logic [$clog2(INIT_BYTES)-1:0] init_idx;
	lcd_byte_t                     init_byte;
	logic [PIXEL_BITS-1:0]         sel_pixel;
	logic [7:0]                    low_byte;   // kept for the second push

	assign lcd_rst   = (state == ST_RESET);
	assign sel_pixel = testpattern ? pattern : pixel;

	// --------------------------------------------------
	// init table
	always_comb begin
		case (init_idx)
			0:       init_byte = {1'b0, SLPOUT};
			1:       init_byte = {1'b0, INVON};
			2:       init_byte = {1'b0, DISPON};
			3:       init_byte = {1'b0, CASET};
			4:       init_byte = {1'b1, X_START[15:8]};
			5:       init_byte = {1'b1, X_START[7:0]};
			6:       init_byte = {1'b1, X_END[15:8]};
			7:       init_byte = {1'b1, X_END[7:0]};
			8:       init_byte = {1'b0, RASET};
			9:       init_byte = {1'b1, Y_START[15:8]};
			10:      init_byte = {1'b1, Y_START[7:0]};
			11:      init_byte = {1'b1, Y_END[15:8]};
			12:      init_byte = {1'b1, Y_END[7:0]};
			13:      init_byte = {1'b0, MADCTL};
			14:      init_byte = {1'b1, MADCTL_BITS};
			15:      init_byte = {1'b0, COLMOD};
			default: init_byte = {1'b1, COLMOD_16BIT};  // last entry
		endcase
	end

	// --------------------------------------------------
	// wait counter limits per state
	always_comb begin
		timed      = 1'b1;
		wait_limit = '0;
		case (state)
			ST_RESET:       wait_limit = WAIT_BITS'(WAIT_RESET);
			ST_AFTER_RESET: wait_limit = WAIT_BITS'(WAIT_AFTER_SLEEP);
			ST_SLEEP_WAIT:  wait_limit = WAIT_BITS'(WAIT_AFTER_SLEEP);
			ST_UPDATE_WAIT: wait_limit = WAIT_BITS'(WAIT_UPDATE - 1);  // WAIT_UPDATE cycles
			default:        timed = 1'b0;
		endcase
	end

	assign wait_done = timed && (wait_ctr == wait_limit);

	// byte towards the FIFO, only when a slot is free
	always_comb begin
		push = !full && (state inside {ST_INIT, ST_START_WRITE, ST_HIGH_BYTE, ST_LOW_BYTE});
		case (state)
			ST_INIT:        push_byte = init_byte;
			ST_START_WRITE: push_byte = {1'b0, RAMWR};
			ST_HIGH_BYTE:   push_byte = {1'b1, sel_pixel[15:8]};  // msb first
			default:        push_byte = {1'b1, low_byte};
		endcase
	end

	// --------------------------------------------------
	// state machine
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state    <= ST_RESET;
			wait_ctr <= '0;
			init_idx <= '0;
			hpix     <= '0;
			vpix     <= '0;
		end else begin
			wait_ctr <= (timed && !wait_done) ? wait_ctr + 1'b1 : '0;
			case (state)
				ST_RESET:       if (wait_done) state <= ST_AFTER_RESET;
				ST_AFTER_RESET: if (wait_done) state <= ST_INIT;
				ST_SLEEP_WAIT:  if (wait_done) state <= ST_INIT;
				ST_UPDATE_WAIT: if (wait_done) state <= ST_UPDATE_ARM;
				ST_UPDATE_ARM:  if (update) state <= ST_START_WRITE;
				ST_START_WRITE: if (!full) state <= ST_FETCH;
				ST_FETCH:       state <= ST_HIGH_BYTE;
				ST_HIGH_BYTE:   if (!full) state <= ST_LOW_BYTE;
				ST_INIT: begin
					if (!full) begin
						if (init_idx == 0) begin
							init_idx <= init_idx + 1'b1;
							state    <= ST_SLEEP_WAIT;  // panel needs time after slpout
						end else if (init_idx == INIT_BYTES - 1) begin
							init_idx <= '0;
							state    <= ST_UPDATE_WAIT;
						end else begin
							init_idx <= init_idx + 1'b1;
						end
					end
				end
				ST_LOW_BYTE: begin
					if (!full) begin
						state <= ST_FETCH;
						if (hpix == HCTR_BITS'(SCREEN_WIDTH - 1)) begin
							hpix <= '0;
							if (vpix == VCTR_BITS'(SCREEN_HEIGHT - 1)) begin
								vpix  <= '0;
								state <= ST_UPDATE_WAIT;  // frame done
							end else begin
								vpix <= vpix + 1'b1;
							end
						end else begin
							hpix <= hpix + 1'b1;
						end
					end
				end
				default: state <= ST_RESET;
			endcase
		end
	end

	// low byte captured together with the high byte push
	always_ff @(posedge in_clk) begin
		if (state == ST_HIGH_BYTE && !full)
			low_byte <= sel_pixel[7:0];
	end

endmodule

// File: hw/byte_fifo.sv
// small FIFO with combinational head read, push while full and pop while empty are dropped
module byte_fifo
	import serial_pkg::*;
(
	input  logic      in_clk,
	input  logic      in_rst,
	input  logic      push,
	input  lcd_byte_t push_byte,
	input  logic      pop,
	output lcd_byte_t head,
	output logic      full,
	output logic      empty
);

	lcd_byte_t          mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;       // occupancy
	logic [FIFO_AW:0]   count_next;
	logic               do_push;
	logic               do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];    // oldest entry

	always_comb begin
		count_next = count;
		if (do_push && !do_pop)
			count_next = count + 1'b1;
		else if (do_pop && !do_push)
			count_next = count - 1'b1;
	end

	// pointers and registered flags
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			full  <= (count_next == (FIFO_AW + 1)'(FIFO_DEPTH));
			empty <= (count_next == '0);
		end
	end

	// storage
	always_ff @(posedge in_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_byte;
	end

endmodule

// File: hw/spi_byte_tx.sv
// write only 4-wire serial shifter, sclk idles high and stops whenever chip select is high
module spi_byte_tx
	import serial_pkg::*;
(
	input  logic      in_clk,
	input  logic      in_rst,
	input  lcd_byte_t head,
	input  logic      empty,
	output logic      pop,
	output logic      lcd_cs,
	output logic      lcd_dc,
	output logic      lcd_sclk,
	output logic      lcd_sda
);

	typedef enum logic {
		ST_IDLE,
		ST_SHIFT
	} tx_state_e;

	tx_state_e           state;
	logic [DIV_BITS-1:0] div_ctr;   // cycles within a half period
	logic [2:0]          bit_ctr;   // bits already sent
	logic [6:0]          shreg;     // bits still to go
	logic                div_done;
	logic                last_bit;  // end of the 8th high phase
	logic                falling;

	assign div_done = (state == ST_SHIFT) && (div_ctr == DIV_BITS'(CLK_DIV - 1));
	assign last_bit = div_done && lcd_sclk && (bit_ctr == 3'd7);
	assign falling  = div_done && lcd_sclk && !last_bit;

	// next byte taken when idle or right at the end of the current one
	assign pop = !empty && (state == ST_IDLE || last_bit);

	// --------------------------------------------------
	// control and pins
	always_ff @(posedge in_clk or posedge in_rst) begin
		if (in_rst) begin
			state    <= ST_IDLE;
			div_ctr  <= '0;
			bit_ctr  <= '0;
			lcd_cs   <= 1'b1;
			lcd_dc   <= 1'b0;
			lcd_sclk <= 1'b1;
			lcd_sda  <= 1'b0;
		end else if (pop) begin
			state    <= ST_SHIFT;
			div_ctr  <= '0;
			bit_ctr  <= '0;
			lcd_cs   <= 1'b0;
			lcd_dc   <= head.dc;           // held for the whole byte
			lcd_sclk <= 1'b0;
			lcd_sda  <= head.payload[7];  // msb first
		end else if (state == ST_SHIFT) begin
			if (!div_done) begin
				div_ctr <= div_ctr + 1'b1;
			end else begin
				div_ctr <= '0;
				if (last_bit) begin
					state   <= ST_IDLE;  // nothing queued
					lcd_cs  <= 1'b1;
					lcd_sda <= 1'b0;
				end else begin
					lcd_sclk <= !lcd_sclk;  // panel samples on the rise
					if (falling) begin
						bit_ctr <= bit_ctr + 1'b1;
						lcd_sda <= shreg[6];
					end
				end
			end
		end
	end

	// shift register
	always_ff @(posedge in_clk) begin
		if (pop)
			shreg <= head.payload[6:0];
		else if (falling)
			shreg <= {shreg[5:0], 1'b0};
	end

endmodule

// File: hw/lcd_top.sv
// serial panel driver top with fixed geometry, hpix/vpix ask for the pixel that is due next
module lcd_top
	import lcd_pkg::*;
	import serial_pkg::*;
(
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  update,
	input  logic                  testpattern,
	input  logic [PIXEL_BITS-1:0] pixel,
	output logic [HCTR_BITS-1:0]  hpix,
	output logic [VCTR_BITS-1:0]  vpix,
	output logic                  lcd_rst,
	output logic                  lcd_cs,
	output logic                  lcd_dc,
	output logic                  lcd_sclk,
	output logic                  lcd_sda
);

	logic                  push;
	logic                  full;
	logic                  pop;
	logic                  empty;
	lcd_byte_t             push_byte;
	lcd_byte_t             head;
	logic [PIXEL_BITS-1:0] pattern;

	// --------------------------------------------------
	// producer
	frame_sequencer u_seq (
		.in_clk      (in_clk),
		.in_rst      (in_rst),
		.update      (update),
		.testpattern (testpattern),
		.pixel       (pixel),
		.pattern     (pattern),
		.full        (full),
		.hpix        (hpix),
		.vpix        (vpix),
		.push        (push),
		.push_byte   (push_byte),
		.lcd_rst     (lcd_rst)
	);

	color_bars u_bars (
		.hpix    (hpix),
		.vpix    (vpix),
		.pattern (pattern)
	);

	// buffer
	byte_fifo u_fifo (
		.in_clk    (in_clk),
		.in_rst    (in_rst),
		.push      (push),
		.push_byte (push_byte),
		.pop       (pop),
		.head      (head),
		.full      (full),
		.empty     (empty)
	);

	// consumer
	spi_byte_tx u_tx (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.head     (head),
		.empty    (empty),
		.pop      (pop),
		.lcd_cs   (lcd_cs),
		.lcd_dc   (lcd_dc),
		.lcd_sclk (lcd_sclk),
		.lcd_sda  (lcd_sda)
	);

endmodule

// File: verification/lcd_assertions.sv
// serial pin and FIFO rules, unused inputs are tied off per bind so their checks stay vacuous
module lcd_assertions (
	input logic in_clk,
	input logic in_rst,
	input logic cs,     // chip select, low active
	input logic sclk,
	input logic dc,
	input logic pop,    // new byte taken by the shifter
	input logic push,
	input logic full
);

	// --------------------------------------------------
	// serial pins
	// clock parked high outside a transfer
	cs_idle_sclk: assert property (@(posedge in_clk) disable iff (in_rst)
		cs |-> sclk)
		else $error("lcd_sclk low while lcd_cs is high");

	// dc only moves when a new byte starts
	dc_hold: assert property (@(posedge in_clk) disable iff (in_rst)
		(!cs && !pop) |=> $stable(dc))
		else $error("lcd_dc changed inside a byte");

	// --------------------------------------------------
	// fifo
	push_not_full: assert property (@(posedge in_clk) disable iff (in_rst)
		push |-> !full)
		else $error("push while the FIFO is full");

endmodule

// File: verification/lcd_tb.sv
// full run covers reset, init and two 128x64 frames, about a million cycles, pixel source seeded
module lcd_tb
	import lcd_pkg::*;
	import serial_pkg::*;
();

	localparam int PIXELS       = SCREEN_WIDTH * SCREEN_HEIGHT;
	localparam int FRAME_BYTES  = 2 * PIXELS + 1;      // ramwr plus two bytes per pixel
	localparam int BYTE_CYCLES  = 16 * CLK_DIV;        // one byte on the wire
	localparam int MAX_DELAY    = WAIT_UPDATE + 64;    // longest random gap before update
	localparam int SETTLE       = WAIT_UPDATE + 4 * BYTE_CYCLES;
	localparam int SETUP_CYCLES = WAIT_RESET + 2 * WAIT_AFTER_SLEEP + INIT_BYTES * BYTE_CYCLES
		+ 2 * (WAIT_UPDATE + MAX_DELAY) + SETTLE + 16;
	localparam int CYCLE_LIMIT  = 2 * (2 * FRAME_BYTES * BYTE_CYCLES + SETUP_CYCLES);

	logic                  in_clk;
	logic                  in_rst;
	logic                  update;
	logic                  testpattern;
	logic [PIXEL_BITS-1:0] pixel = '0;
	logic [HCTR_BITS-1:0]  hpix;
	logic [VCTR_BITS-1:0]  vpix;
	logic                  lcd_rst, lcd_cs, lcd_dc, lcd_sclk, lcd_sda;

	logic [15:0] pix_mem [PIXELS];   // external frame, row order
	logic [8:0]  rx_q [$];           // {dc, byte} as seen on the pins
	logic [8:0]  exp_q [$];          // model output
	logic [7:0]  rx_shift;
	int          rx_bits = 0;
	int          seed = 44;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          rst_cycles;
	int          delay;

	lcd_top dut (
		.in_clk      (in_clk),
		.in_rst      (in_rst),
		.update      (update),
		.testpattern (testpattern),
		.pixel       (pixel),
		.hpix        (hpix),
		.vpix        (vpix),
		.lcd_rst     (lcd_rst),
		.lcd_cs      (lcd_cs),
		.lcd_dc      (lcd_dc),
		.lcd_sclk    (lcd_sclk),
		.lcd_sda     (lcd_sda)
	);

	// serial pin rules in the shifter, push rule in the fifo
	bind spi_byte_tx lcd_assertions tx_checks (
		.in_clk (in_clk), .in_rst (in_rst), .cs (lcd_cs), .sclk (lcd_sclk),
		.dc (lcd_dc), .pop (pop), .push (1'b0), .full (1'b0)
	);
	bind byte_fifo lcd_assertions fifo_checks (
		.in_clk (in_clk), .in_rst (in_rst), .cs (1'b1), .sclk (1'b1),
		.dc (1'b0), .pop (pop), .push (push), .full (full)
	);

	initial begin
		in_clk = 1'b0;
		forever #4 in_clk = ~in_clk;
	end

	// pixel follows the requested coordinates one edge later
	always @(posedge in_clk) begin
		pixel <= pix_mem[int'(vpix) * SCREEN_WIDTH + int'(hpix)];
	end

	// --------------------------------------------------
	// spi decoder, panel side view
	always @(posedge lcd_sclk) begin
		if (lcd_cs === 1'b0) begin
			rx_shift = {rx_shift[6:0], lcd_sda};  // msb first
			rx_bits  = rx_bits + 1;
			if (rx_bits == 8) begin
				rx_q.push_back({lcd_dc, rx_shift});
				rx_bits = 0;
			end
		end
	end

	// hang guard
	always @(posedge in_clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
			errors = errors + 1;
			end_run();
		end
	end

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks = checks + 1;
		if (actual !== expected) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
				$time, name, actual, expected);
		end
	endtask

	task automatic end_run();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	// --------------------------------------------------
	// reference model
	task automatic queue_command(input logic [7:0] op);
		exp_q.push_back({1'b0, op});
	endtask

	task automatic queue_word(input logic [15:0] w);
		exp_q.push_back({1'b1, w[15:8]});  // high byte first
		exp_q.push_back({1'b1, w[7:0]});
	endtask

	task automatic build_expected();
		int          bar;
		logic [15:0] px;
		queue_command(SLPOUT);
		queue_command(INVON);
		queue_command(DISPON);
		queue_command(CASET);
		queue_word(16'(SCREEN_HOFFS));
		queue_word(16'(SCREEN_HOFFS + SCREEN_WIDTH - 1));
		queue_command(RASET);
		queue_word(16'(SCREEN_VOFFS));
		queue_word(16'(SCREEN_VOFFS + SCREEN_HEIGHT - 1));
		queue_command(MADCTL);
		exp_q.push_back({1'b1, MADCTL_BITS});
		queue_command(COLMOD);
		exp_q.push_back({1'b1, 8'h55});  // 16 bit rgb565
		queue_command(RAMWR);            // external frame
		for (int y = 0; y < SCREEN_HEIGHT; y++)
			for (int x = 0; x < SCREEN_WIDTH; x++)
				queue_word(pix_mem[y * SCREEN_WIDTH + x]);
		queue_command(RAMWR);            // colour bars
		for (int y = 0; y < SCREEN_HEIGHT; y++) begin
			for (int x = 0; x < SCREEN_WIDTH; x++) begin
				bar = x / (SCREEN_WIDTH / 8);
				px  = 16'h0000;
				if (bar & 4) px = px | 16'hf800;
				if (bar & 2) px = px | 16'h07e0;
				if (bar & 1) px = px | 16'h001f;
				queue_word(px);
			end
		end
	endtask

	// --------------------------------------------------
	// sequencing helpers
	task automatic wait_bytes(input int n);
		while (rx_q.size() < n)
			@(posedge in_clk);
	endtask

	task automatic wait_cs_high();
		while (lcd_cs !== 1'b1)
			@(posedge in_clk);
	endtask

	task automatic check_bytes(input int first, input int n);
		for (int i = first; i < first + n; i++)
			compare_value($sformatf("rx byte %0d {dc,data}", i), rx_q[i], exp_q[i]);
	endtask

	task automatic expect_quiet(input int n, input int count);
		repeat (n) @(posedge in_clk);
		compare_value("bytes while update low", rx_q.size(), count);
	endtask

	task automatic pulse_update();
		@(posedge in_clk);
		update <= 1'b1;
		@(posedge in_clk);
		update <= 1'b0;
	endtask

	// --------------------------------------------------
	// main flow
	initial begin
		in_rst      = 1'b1;
		update      = 1'b0;
		testpattern = 1'b0;
		for (int i = 0; i < PIXELS; i++)
			pix_mem[i] = 16'($random(seed));
		build_expected();
		// pins looked at mid cycle while reset holds
		repeat (2) begin
			@(negedge in_clk);
			compare_value("lcd_rst in reset", lcd_rst, 1);
			compare_value("lcd_cs in reset", lcd_cs, 1);
			compare_value("lcd_sclk in reset", lcd_sclk, 1);
		end
		@(posedge in_clk);
		in_rst <= 1'b0;
		rst_cycles = 0;
		@(posedge in_clk);
		while (lcd_rst === 1'b1 && rst_cycles < 64) begin
			rst_cycles = rst_cycles + 1;
			compare_value("lcd_cs during panel reset", lcd_cs, 1);
			compare_value("lcd_sclk during panel reset", lcd_sclk, 1);
			@(posedge in_clk);
		end
		compare_value("lcd_rst high cycles", rst_cycles, WAIT_RESET + 1);
		compare_value("bytes before lcd_rst falls", rx_q.size(), 0);
		wait_bytes(INIT_BYTES);
		check_bytes(0, INIT_BYTES);
		// external frame after a random gap
		delay = WAIT_UPDATE + 1 + ($random(seed) & 63);
		expect_quiet(delay, INIT_BYTES);
		pulse_update();
		wait_bytes(INIT_BYTES + FRAME_BYTES);
		wait_cs_high();  // end of frame
		check_bytes(INIT_BYTES, FRAME_BYTES);
		// colour bar frame
		@(posedge in_clk);
		testpattern <= 1'b1;
		delay = WAIT_UPDATE + 1 + ($random(seed) & 63);
		expect_quiet(delay, INIT_BYTES + FRAME_BYTES);
		pulse_update();
		wait_bytes(INIT_BYTES + 2 * FRAME_BYTES);
		wait_cs_high();
		check_bytes(INIT_BYTES + FRAME_BYTES, FRAME_BYTES);
		repeat (SETTLE) @(posedge in_clk);
		compare_value("total bytes", rx_q.size(), exp_q.size());
		end_run();
	end

endmodule

// File: project.f
hw/lcd_pkg.sv
hw/serial_pkg.sv
hw/color_bars.sv
hw/frame_sequencer.sv
hw/byte_fifo.sv
hw/spi_byte_tx.sv
hw/lcd_top.sv
verification/lcd_assertions.sv
verification/lcd_tb.sv

// File: Makefile
# Verilator build and run for the LCD driver testbench

VERILATOR ?= verilator
TOP       ?= lcd_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
